// ==== source/boundary_parity_scan.sv ====
`default_nettype none

module boundary_parity_scan (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    go,
    input  decoder_geometry_pkg::cluster_snapshot_t captured,
    output logic                                    done,
    output logic                                    final_cardinality
);
    import decoder_geometry_pkg::*;

    logic        busy;
    pu_index_t   index;
    // own address of the PU at index, walked in step
    pu_address_t addr;
    logic        hit;

    // root that is odd and touches a boundary
    assign hit = (captured.roots[index] == addr)
              && captured.is_odd_cardinalities[index]
              && captured.is_touching_boundaries[index];

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (go) begin
                busy <= 1'b1;
            end else if (busy && index == pu_count - 1) begin
                // last PU folded in this cycle
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // walk x fastest, then z, then round
    always_ff @(posedge clk) begin
        if (go) begin
            index             <= '0;
            addr              <= '0;
            final_cardinality <= 1'b0;
        end else if (busy) begin
            index             <= index + 1'b1;
            final_cardinality <= final_cardinality ^ hit;
            if (addr.x == code_distance_x - 1) begin
                addr.x <= '0;
                if (addr.z == code_distance_z - 1) begin
                    addr.z     <= '0;
                    addr.round <= addr.round + 1'b1;
                end else begin
                    addr.z <= addr.z + 1'b1;
                end
            end else begin
                addr.x <= addr.x + 1'b1;
            end
        end
    end

    // sequencer waits for done before another scan
    a_go_while_idle: assert property (@(posedge clk) disable iff (reset)
        go |-> !busy)
        else $error("scan go arrived during a running scan");

endmodule

`default_nettype wire

// ==== source/decoder_geometry_pkg.sv ====
`default_nettype none

package decoder_geometry_pkg;

    // lattice size in the two spatial directions
    localparam int code_distance_x = 3;
    localparam int code_distance_z = 3;

    // time direction follows the larger distance
    localparam int measurement_rounds =
        (code_distance_x > code_distance_z) ? code_distance_x : code_distance_z;

    // bits per coordinate, shared by round, z and x
    localparam int coord_width = $clog2(measurement_rounds);

    localparam int pu_count = code_distance_x * code_distance_z * measurement_rounds;
    localparam int pu_index_width = $clog2(pu_count);

    // one address word per PU
    typedef struct packed {
        logic [coord_width-1:0] round;
        logic [coord_width-1:0] z;
        logic [coord_width-1:0] x;
    } pu_address_t;

    // PU number, x fastest, then z, then round
    typedef logic [pu_index_width-1:0] pu_index_t;

    // cluster state of all PUs at the start of a round
    typedef struct packed {
        logic [pu_count-1:0]          is_touching_boundaries;
        logic [pu_count-1:0]          is_odd_cardinalities;
        pu_address_t [pu_count-1:0]   roots;
    } cluster_snapshot_t;

endpackage

`default_nettype wire

// ==== source/decoder_stage_controller.sv ====
`default_nettype none

module decoder_stage_controller #(
    parameter int boundary_grow_delay    = 12,
    parameter int spread_cluster_delay   = 12,
    parameter int sync_odd_cluster_delay = 12,
    parameter int message_flying_delay   = 4,
    parameter int deadlock_threshold     = decoder_geometry_pkg::pu_count * 10
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    round_req,
    output logic                                    round_ack,
    input  decoder_geometry_pkg::cluster_snapshot_t snapshot,
    input  stage_ctrl_pkg::downstream_status_t      downstream,
    output stage_ctrl_pkg::phase_code_t             phase,
    output logic                                    result_req,
    input  logic                                    result_ack,
    output stage_ctrl_pkg::decode_result_t          result
);
    import decoder_geometry_pkg::*;
    import stage_ctrl_pkg::*;

    cluster_snapshot_t captured;
    decode_result_t    result_data;
    logic              ready;
    logic              round_start;
    logic              flying;
    logic              odd_clusters;
    logic              scan_go;
    logic              scan_done;
    logic              final_cardinality;
    logic              result_load;
    logic              sender_busy;

    // round handshake, snapshot and network status
    round_intake #(
        .message_flying_delay(message_flying_delay)
    ) i_intake (
        .clk          (clk),
        .reset        (reset),
        .round_req    (round_req),
        .snapshot     (snapshot),
        .downstream   (downstream),
        .ready        (ready),
        .round_ack    (round_ack),
        .round_start  (round_start),
        .captured     (captured),
        .flying       (flying),
        .odd_clusters (odd_clusters)
    );

    // stage FSM and counters
    stage_sequencer #(
        .spread_cluster_delay   (spread_cluster_delay),
        .sync_odd_cluster_delay (sync_odd_cluster_delay),
        .boundary_grow_delay    (boundary_grow_delay),
        .deadlock_threshold     (deadlock_threshold)
    ) i_sequencer (
        .clk               (clk),
        .reset             (reset),
        .round_start       (round_start),
        .flying            (flying),
        .odd_clusters      (odd_clusters),
        .scan_done         (scan_done),
        .final_cardinality (final_cardinality),
        .sender_busy       (sender_busy),
        .ready             (ready),
        .phase             (phase),
        .scan_go           (scan_go),
        .result_load       (result_load),
        .result_data       (result_data)
    );

    // serial boundary cardinality over the captured snapshot
    boundary_parity_scan i_scan (
        .clk               (clk),
        .reset             (reset),
        .go                (scan_go),
        .captured          (captured),
        .done              (scan_done),
        .final_cardinality (final_cardinality)
    );

    // result handshake
    result_sender i_sender (
        .clk        (clk),
        .reset      (reset),
        .load       (result_load),
        .data       (result_data),
        .result_ack (result_ack),
        .busy       (sender_busy),
        .result_req (result_req),
        .result     (result)
    );

endmodule

`default_nettype wire

// ==== source/result_sender.sv ====
`default_nettype none

module result_sender (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           load,
    input  stage_ctrl_pkg::decode_result_t data,
    input  logic                           result_ack,
    output logic                           busy,
    output logic                           result_req,
    output stage_ctrl_pkg::decode_result_t result
);

    // sending half of the four-phase result handshake
    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            result_req <= 1'b0;
        end else begin
            if (load) begin
                busy       <= 1'b1;
                result_req <= 1'b1;
            end else if (result_req && result_ack) begin
                // receiver took the word
                result_req <= 1'b0;
            end else if (busy && !result_req && !result_ack) begin
                // ack back low, free for the next round
                busy <= 1'b0;
            end
        end
    end

    // held from load until the next load
    always_ff @(posedge clk) begin
        if (load) begin
            result <= data;
        end
    end

    // word may not move under a raised req
    a_result_stable: assert property (@(posedge clk) disable iff (reset)
        result_req && $past(result_req) |-> $stable(result))
        else $error("result changed while result_req was high");

endmodule

`default_nettype wire

// ==== source/round_intake.sv ====
`default_nettype none

module round_intake #(
    parameter int message_flying_delay = 4
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    round_req,
    input  decoder_geometry_pkg::cluster_snapshot_t snapshot,
    input  stage_ctrl_pkg::downstream_status_t      downstream,
    input  logic                                    ready,
    output logic                                    round_ack,
    output logic                                    round_start,
    output decoder_geometry_pkg::cluster_snapshot_t captured,
    output logic                                    flying,
    output logic                                    odd_clusters
);

    // one bit per cycle of network travel time
    logic [message_flying_delay-1:0] flying_hold;
    logic                            accept;

    // fresh request, not yet acked, sequencer free
    assign accept = round_req && !round_ack && ready;

    // receiving half of the four-phase round handshake
    always_ff @(posedge clk) begin
        if (reset) begin
            round_ack   <= 1'b0;
            round_start <= 1'b0;
        end else begin
            // single-cycle start toward the sequencer
            round_start <= accept;
            if (accept) begin
                round_ack <= 1'b1;
            end else if (!round_req) begin
                // requester dropped req, close the handshake
                round_ack <= 1'b0;
            end
        end
    end

    // snapshot is stable while req is high
    always_ff @(posedge clk) begin
        if (accept) begin
            captured <= snapshot;
        end
    end

    // downstream status, registered
    always_ff @(posedge clk) begin
        if (reset) begin
            flying_hold  <= '0;
            odd_clusters <= 1'b0;
        end else begin
            // shift in the raw flag
            // the OR below keeps it up for the whole window
            flying_hold  <= (flying_hold << 1)
                          | message_flying_delay'(downstream.message_flying);
            odd_clusters <= downstream.odd_clusters;
        end
    end

    // high until the last message has surely landed
    assign flying = |flying_hold;

    // ack only answers a request that was seen high
    a_ack_follows_req: assert property (@(posedge clk) disable iff (reset)
        $rose(round_ack) |-> $past(round_req))
        else $error("round_ack rose without a pending round_req");

endmodule

`default_nettype wire

// ==== source/stage_ctrl_pkg.sv ====
`default_nettype none

package stage_ctrl_pkg;

    // decoding stages of one round
    typedef enum logic [2:0] {
        stage_idle,
        stage_loading,
        stage_spread,
        stage_sync,
        stage_grow,
        stage_result
    } stage_t;

    // phase code seen by the PU array
    typedef enum logic [1:0] {
        phase_none   = 2'd0,
        phase_spread = 2'd1,
        phase_grow   = 2'd2,
        phase_sync   = 2'd3
    } phase_code_t;

    // counter widths
    localparam int iteration_width = 8;
    localparam int cycle_width     = 32;

    typedef logic [iteration_width-1:0] iteration_count_t;
    typedef logic [cycle_width-1:0]     cycle_count_t;

    // status from the message network
    typedef struct packed {
        logic message_flying;
        logic odd_clusters;
    } downstream_status_t;

    // one result word per round
    typedef struct packed {
        logic             final_cardinality;
        logic             deadlock;
        iteration_count_t iteration_count;
        cycle_count_t     cycle_count;
    } decode_result_t;

endpackage

`default_nettype wire

// ==== source/stage_sequencer.sv ====
`default_nettype none

module stage_sequencer #(
    parameter int spread_cluster_delay   = 12,
    parameter int sync_odd_cluster_delay = 12,
    parameter int boundary_grow_delay    = 12,
    parameter int deadlock_threshold     = decoder_geometry_pkg::pu_count * 10
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           round_start,
    input  logic                           flying,
    input  logic                           odd_clusters,
    input  logic                           scan_done,
    input  logic                           final_cardinality,
    input  logic                           sender_busy,
    output logic                           ready,
    output stage_ctrl_pkg::phase_code_t    phase,
    output logic                           scan_go,
    output logic                           result_load,
    output stage_ctrl_pkg::decode_result_t result_data
);
    import stage_ctrl_pkg::*;

    localparam int spread_sync_max =
        (spread_cluster_delay > sync_odd_cluster_delay) ?
        spread_cluster_delay : sync_odd_cluster_delay;
    localparam int max_delay =
        (spread_sync_max > boundary_grow_delay) ? spread_sync_max : boundary_grow_delay;
    localparam int delay_width = $clog2(max_delay + 1);
    // room for threshold plus the cycle that trips it
    localparam int stall_width = $clog2(deadlock_threshold + 3);

    stage_t                 stage;
    logic [delay_width-1:0] delay_count;
    logic [stall_width-1:0] stall_count;
    logic                   delay_done;
    logic                   stalled;
    logic                   odd_advance;
    logic                   deadlock;
    iteration_count_t       iteration_count;
    cycle_count_t           cycle_count;

    // minimum stay of the current stage reached
    always_comb begin
        case (stage)
            stage_spread: delay_done = delay_count >= spread_cluster_delay;
            stage_sync:   delay_done = delay_count >= sync_odd_cluster_delay;
            stage_grow:   delay_done = delay_count >= boundary_grow_delay;
            default:      delay_done = 1'b0;
        endcase
    end

    // network never settles
    assign stalled = flying && (stall_count > deadlock_threshold);
    // sync settled with odd clusters left, one more iteration
    assign odd_advance = (stage == stage_sync) && delay_done && !flying && odd_clusters;

    // idle only once the last result has left
    assign ready = (stage == stage_idle) && !sender_busy && !result_load;

    // stage FSM
    always_ff @(posedge clk) begin
        if (reset) begin
            stage       <= stage_idle;
            delay_count <= '0;
            scan_go     <= 1'b0;
            result_load <= 1'b0;
            deadlock    <= 1'b0;
        end else begin
            scan_go     <= 1'b0;
            result_load <= 1'b0;
            case (stage)
                stage_idle: begin
                    if (round_start) begin
                        stage <= stage_loading;
                    end
                end
                stage_loading: begin
                    // single-cycle load from the captured snapshot
                    stage       <= stage_spread;
                    delay_count <= '0;
                    deadlock    <= 1'b0;
                end
                stage_spread: begin
                    if (!delay_done) begin
                        delay_count <= delay_count + 1'b1;
                    end else if (!flying) begin
                        stage       <= stage_sync;
                        delay_count <= '0;
                    end else if (stalled) begin
                        stage    <= stage_result;
                        scan_go  <= 1'b1;
                        deadlock <= 1'b1;
                    end
                end
                stage_sync: begin
                    if (!delay_done) begin
                        delay_count <= delay_count + 1'b1;
                    end else if (!flying) begin
                        // odd clusters grow again, else decoding is done
                        stage       <= odd_clusters ? stage_grow : stage_result;
                        scan_go     <= !odd_clusters;
                        delay_count <= '0;
                    end else if (stalled) begin
                        stage    <= stage_result;
                        scan_go  <= 1'b1;
                        deadlock <= 1'b1;
                    end
                end
                stage_grow: begin
                    if (!delay_done) begin
                        delay_count <= delay_count + 1'b1;
                    end else if (!flying) begin
                        stage       <= stage_spread;
                        delay_count <= '0;
                    end
                end
                stage_result: begin
                    // wait for the boundary scan
                    if (scan_done) begin
                        stage       <= stage_idle;
                        result_load <= 1'b1;
                    end
                end
                default: stage <= stage_idle;
            endcase
        end
    end

    // iteration, cycle and stall counters
    always_ff @(posedge clk) begin
        if (reset) begin
            iteration_count <= '0;
            cycle_count     <= '0;
            stall_count     <= '0;
        end else begin
            if (stage == stage_loading) begin
                iteration_count <= '0;
            end else if (odd_advance) begin
                iteration_count <= iteration_count + 1'b1;
            end
            // loading is the first counted cycle
            if (stage == stage_loading) begin
                cycle_count <= 1;
            end else if (stage == stage_spread || stage == stage_sync ||
                         stage == stage_grow) begin
                cycle_count <= cycle_count + 1'b1;
            end
            // grow restarts the stall window
            if (stage == stage_spread || stage == stage_sync) begin
                stall_count <= stall_count + 1'b1;
            end else if (stage != stage_result) begin
                stall_count <= '0;
            end
        end
    end

    // result word, latched with the scan outcome
    always_ff @(posedge clk) begin
        if (stage == stage_result && scan_done) begin
            result_data.final_cardinality <= final_cardinality;
            result_data.deadlock          <= deadlock;
            result_data.iteration_count   <= iteration_count;
            result_data.cycle_count       <= cycle_count;
        end
    end

    // outward phase code
    always_comb begin
        case (stage)
            stage_spread: phase = phase_spread;
            stage_grow:   phase = phase_grow;
            stage_sync:   phase = phase_sync;
            default:      phase = phase_none;
        endcase
    end

    // scan launch only on entry to the result stage
    a_scan_go_in_result: assert property (@(posedge clk) disable iff (reset)
        scan_go |-> stage == stage_result)
        else $error("scan_go raised outside the result stage");

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+verif
source/decoder_geometry_pkg.sv
source/stage_ctrl_pkg.sv
source/round_intake.sv
source/stage_sequencer.sv
source/boundary_parity_scan.sv
source/result_sender.sv
source/decoder_stage_controller.sv
verif/tb_decoder_stage_controller.sv

// ==== verif/tb_cluster_model.svh ====
`ifndef TB_CLUSTER_MODEL_SVH
`define TB_CLUSTER_MODEL_SVH

// xorshift32 step, stays nonzero for a nonzero state
function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] s;
    s = state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

// address of PU number index, x fastest, then z, then round
function automatic pu_address_t home_address(input int index);
    pu_address_t a;
    a.x     = coord_width'(index % code_distance_x);
    a.z     = coord_width'((index / code_distance_x) % code_distance_z);
    a.round = coord_width'(index / (code_distance_x * code_distance_z));
    return a;
endfunction

// parity of roots that are odd and touch a boundary
function automatic logic boundary_parity(input cluster_snapshot_t snap);
    logic parity;
    parity = 1'b0;
    for (int i = 0; i < pu_count; i++) begin
        if (snap.roots[i] == home_address(i) && snap.is_odd_cardinalities[i]
                && snap.is_touching_boundaries[i]) begin
            parity = ~parity;
        end
    end
    return parity;
endfunction

`endif

// ==== verif/tb_decoder_stage_controller.sv ====
`default_nettype none

module tb_decoder_stage_controller;
    timeunit 1ns;
    timeprecision 1ps;

    import decoder_geometry_pkg::*;
    import stage_ctrl_pkg::*;

    `include "tb_cluster_model.svh"

    localparam logic [31:0] seed           = 32'hf5e0_4731;
    localparam int round_count             = 10;
    localparam int backpressure_round      = 2;
    localparam int deadlock_round          = 5;
    localparam int spread_cluster_delay    = 12;
    localparam int sync_odd_cluster_delay  = 12;
    localparam int boundary_grow_delay     = 12;
    localparam int message_flying_delay    = 4;
    localparam int deadlock_threshold      = pu_count * 10;
    localparam int watchdog_cycles         = round_count * (3 * deadlock_threshold + 200);

    logic               clk;
    logic               reset;
    logic               round_req;
    logic               round_ack;
    cluster_snapshot_t  snapshot;
    downstream_status_t downstream;
    phase_code_t        phase;
    logic               result_req;
    logic               result_ack;
    decode_result_t     result;

    // random streams, stimulus and network model apart
    logic [31:0]       stim_state;
    logic [31:0]       net_state;
    // per-round model state
    cluster_snapshot_t sent_snapshot;
    logic              hold_flying;
    logic              first_req_seen;
    int                odd_target;
    int                sync_visits;
    int                grow_moves;
    int                active_cycles;
    int                flying_left;
    phase_code_t       last_phase;
    int                check_count;
    int                value_errors;
    int                protocol_errors;

    decoder_stage_controller #(
        .boundary_grow_delay    (boundary_grow_delay),
        .spread_cluster_delay   (spread_cluster_delay),
        .sync_odd_cluster_delay (sync_odd_cluster_delay),
        .message_flying_delay   (message_flying_delay),
        .deadlock_threshold     (deadlock_threshold)
    ) i_dut (
        .clk        (clk),
        .reset      (reset),
        .round_req  (round_req),
        .round_ack  (round_ack),
        .snapshot   (snapshot),
        .downstream (downstream),
        .phase      (phase),
        .result_req (result_req),
        .result_ack (result_ack),
        .result     (result)
    );

    // 4 ns period
    always #2 clk = ~clk;

    // network model, reacts to phase a little after the edge
    always @(posedge clk) begin
        #1;
        if (reset) begin
            last_phase  = phase_none;
            flying_left = 0;
        end else begin
            if (phase != last_phase) begin
                if (phase == phase_sync) begin
                    sync_visits++;
                end
                if (last_phase == phase_sync && phase == phase_grow) begin
                    grow_moves++;
                end
                // messages in flight for a while after every phase change
                net_state   = xorshift32(net_state);
                flying_left = 2 + int'(net_state % 16);
            end else if (flying_left > 0) begin
                flying_left--;
            end
            if (phase != phase_none) begin
                active_cycles++;
            end
            last_phase = phase;
        end
        downstream.message_flying = hold_flying || (flying_left > 0);
        // odd clusters left on the first K sync visits only
        downstream.odd_clusters   = (phase == phase_sync) && (sync_visits <= odd_target);
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic next_stim(output logic [31:0] v);
        stim_state = xorshift32(stim_state);
        v = stim_state;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected)
        else begin
            value_errors++;
            $display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    // random snapshot, roughly half the PUs their own root
    task automatic start_round(input int index);
        logic [31:0]       v;
        cluster_snapshot_t snap;
        snap = '0;
        for (int i = 0; i < pu_count; i++) begin
            next_stim(v);
            snap.is_touching_boundaries[i] = v[0];
            snap.is_odd_cardinalities[i]   = v[1];
            if (v[2]) begin
                snap.roots[i] = home_address(i);
            end else begin
                snap.roots[i] = v[8 +: $bits(pu_address_t)];
            end
        end
        next_stim(v);
        hold_flying    = (index == deadlock_round);
        odd_target     = hold_flying ? 0 : int'(v % 4);
        sync_visits    = 0;
        grow_moves     = 0;
        active_cycles  = 0;
        sent_snapshot  = snap;
        first_req_seen = 1'b1;
        snapshot       = snap;
        round_req      = 1'b1;
    endtask

    // complete the round handshake, then check the result word
    task automatic finish_round();
        int bound;
        do begin
            next_cycle();
        end while (!round_ack);
        round_req = 1'b0;
        do begin
            next_cycle();
        end while (round_ack);
        do begin
            next_cycle();
        end while (!result_req);
        check_value("final_cardinality", boundary_parity(sent_snapshot),
                    result.final_cardinality);
        check_value("deadlock", hold_flying, result.deadlock);
        check_value("iteration_count", odd_target, result.iteration_count);
        check_value("iteration_count vs sync-to-grow moves", grow_moves,
                    result.iteration_count);
        check_value("cycle_count vs active phase cycles", active_cycles + 1,
                    result.cycle_count);
        if (hold_flying) begin
            check_value("cycle_count past deadlock threshold", 1,
                        result.cycle_count > deadlock_threshold);
        end else begin
            // spread and sync once, plus grow, spread, sync per iteration
            bound = spread_cluster_delay + sync_odd_cluster_delay + 3
                  + odd_target * (spread_cluster_delay + sync_odd_cluster_delay
                  + boundary_grow_delay + 3);
            check_value("cycle_count lower bound", 1, result.cycle_count >= bound);
        end
    endtask

    task automatic acknowledge_result();
        logic [31:0] v;
        next_stim(v);
        repeat (v % 4) next_cycle();
        result_ack = 1'b1;
        do begin
            next_cycle();
        end while (result_req);
        result_ack = 1'b0;
        next_cycle();
    endtask

    initial begin
        int r;
        clk             = 1'b0;
        reset           = 1'b1;
        round_req       = 1'b0;
        result_ack      = 1'b0;
        snapshot        = '0;
        downstream      = '0;
        stim_state      = seed;
        net_state       = xorshift32(seed ^ 32'h5bd1_e995);
        sent_snapshot   = '0;
        hold_flying     = 1'b0;
        first_req_seen  = 1'b0;
        odd_target      = 0;
        sync_visits     = 0;
        grow_moves      = 0;
        active_cycles   = 0;
        flying_left     = 0;
        last_phase      = phase_none;
        check_count     = 0;
        value_errors    = 0;
        protocol_errors = 0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        // quiet stretch before the first request
        repeat (8) next_cycle();
        start_round(0);
        for (r = 0; r < round_count; r++) begin
            finish_round();
            if (r == backpressure_round) begin
                // next request while the result is still unacknowledged
                start_round(r + 1);
                repeat (30) begin
                    next_cycle();
                    check_value("round_ack under back-pressure", 0, round_ack);
                end
                acknowledge_result();
            end else begin
                acknowledge_result();
                if (r + 1 < round_count) begin
                    start_round(r + 1);
                end
            end
        end
        repeat (10) next_cycle();
        $display("checks %0d, value errors %0d, protocol errors %0d",
                 check_count, value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // bounded by the worst-case length of every round
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired before all rounds completed");
        $display("Simulation failed");
        $finish;
    end

    // outputs stay at rest until the first request
    a_quiet_after_reset: assert property (@(posedge clk) disable iff (reset)
        !first_req_seen |-> !round_ack && !result_req && phase == phase_none)
        else begin
            protocol_errors++;
            $display("outputs left their reset state before the first request");
        end

    a_ack_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(round_ack) |-> $past(round_req))
        else begin
            protocol_errors++;
            $display("round_ack rose while round_req was low");
        end

    a_ack_fall: assert property (@(posedge clk) disable iff (reset)
        $fell(round_ack) |-> $past(!round_req))
        else begin
            protocol_errors++;
            $display("round_ack fell while round_req was still high");
        end

    a_result_held: assert property (@(posedge clk) disable iff (reset)
        result_req && $past(result_req) |-> $stable(result))
        else begin
            protocol_errors++;
            $display("result word changed while result_req was high");
        end

    // req drops only in answer to ack
    a_req_until_ack: assert property (@(posedge clk) disable iff (reset)
        $fell(result_req) |-> $past(result_ack))
        else begin
            protocol_errors++;
            $display("result_req fell before result_ack was given");
        end

    // no new round while a result handshake is open
    a_no_ack_pending: assert property (@(posedge clk) disable iff (reset)
        $rose(round_ack) |-> $past(!result_req && !result_ack))
        else begin
            protocol_errors++;
            $display("round_ack given while a result was still unacknowledged");
        end

endmodule

`default_nettype wire
